// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [31:0] rv_inst_t;
    typedef logic [4:0]  rv_reg_t;
    typedef logic [6:0]  rv_opcode_t;
    typedef logic [2:0]  rv_funct3_t;
    typedef logic [6:0]  rv_funct7_t;
    typedef logic [11:0] rv_csr_addr_t;

    // major opcodes
    localparam rv_opcode_t OPC_OP        = 7'b0110011;
    localparam rv_opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam rv_opcode_t OPC_OP_32     = 7'b0111011;
    localparam rv_opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam rv_opcode_t OPC_LOAD      = 7'b0000011;
    localparam rv_opcode_t OPC_STORE     = 7'b0100011;
    localparam rv_opcode_t OPC_BRANCH    = 7'b1100011;
    localparam rv_opcode_t OPC_JAL       = 7'b1101111;
    localparam rv_opcode_t OPC_JALR      = 7'b1100111;
    localparam rv_opcode_t OPC_LUI       = 7'b0110111;
    localparam rv_opcode_t OPC_AUIPC     = 7'b0010111;
    localparam rv_opcode_t OPC_SYSTEM    = 7'b1110011;

    localparam rv_funct7_t F7_BASE   = 7'b0000000;
    localparam rv_funct7_t F7_ALT    = 7'b0100000; // sub / sra
    localparam rv_funct7_t F7_MULDIV = 7'b0000001;

    // integer funct3
    localparam rv_funct3_t F3_ADD  = 3'b000;
    localparam rv_funct3_t F3_SLL  = 3'b001;
    localparam rv_funct3_t F3_SLT  = 3'b010;
    localparam rv_funct3_t F3_SLTU = 3'b011;
    localparam rv_funct3_t F3_XOR  = 3'b100;
    localparam rv_funct3_t F3_SR   = 3'b101; // srl and sra
    localparam rv_funct3_t F3_OR   = 3'b110;
    localparam rv_funct3_t F3_AND  = 3'b111;

    // M extension funct3
    localparam rv_funct3_t F3_MUL  = 3'b000;
    localparam rv_funct3_t F3_DIV  = 3'b100;
    localparam rv_funct3_t F3_DIVU = 3'b101;
    localparam rv_funct3_t F3_REM  = 3'b110;
    localparam rv_funct3_t F3_REMU = 3'b111;

    localparam rv_funct3_t F3_BEQ  = 3'b000;
    localparam rv_funct3_t F3_BNE  = 3'b001;
    localparam rv_funct3_t F3_BLT  = 3'b100;
    localparam rv_funct3_t F3_BGE  = 3'b101;
    localparam rv_funct3_t F3_BLTU = 3'b110;
    localparam rv_funct3_t F3_BGEU = 3'b111;

    localparam rv_funct3_t F3_CSRRW = 3'b001;
    localparam rv_funct3_t F3_CSRRS = 3'b010;

    localparam rv_inst_t INST_ECALL  = 32'h0000_0073;
    localparam rv_inst_t INST_EBREAK = 32'h0010_0073;
    localparam rv_inst_t INST_MRET   = 32'h3020_0073;

endpackage

// ==== decode_ctrl_pkg.sv ====
package decode_ctrl_pkg;
    import rv_isa_pkg::*;

    // zero encodings chosen so that an idle bundle is all zeros
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU // branch compares
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHAMT
    } imm_sel_e;

    typedef enum logic [1:0] {SRC_A_RS1 = 2'd0, SRC_A_PC, SRC_A_ZERO} src_a_e;
    typedef enum logic [1:0] {SRC_B_RS2 = 2'd0, SRC_B_IMM, SRC_B_FOUR} src_b_e;
    typedef enum logic [1:0] {MEM_BYTE = 2'd0, MEM_HALF, MEM_WORD, MEM_DOUBLE} mem_size_e;
    typedef enum logic [1:0] {CSR_NONE = 2'd0, CSR_RW, CSR_RS} csr_op_e;

    typedef struct packed {
        logic         reg_wen;
        rv_reg_t      rd;
        rv_reg_t      rs1;
        rv_reg_t      rs2;
        imm_sel_e     imm_sel;
        alu_op_e      alu_op;
        src_a_e       src_a;
        src_b_e       src_b;
        logic         is_word;      // 32-bit result, sign extended
        logic         is_mul;
        logic         is_div;
        logic         mem_read;
        logic         mem_write;
        mem_size_e    mem_size;
        logic         mem_unsigned;
        logic         branch;
        logic         jump;
        logic         jalr;
        csr_op_e      csr_op;
        rv_csr_addr_t csr_addr;
        logic         ecall;
        logic         mret;
        logic         ebreak;
        logic         illegal;
    } decode_ctrl_t;

    localparam decode_ctrl_t CTRL_NOP = '{
        reg_wen: 1'b0, rd: '0, rs1: '0, rs2: '0,
        imm_sel: IMM_NONE, alu_op: ALU_ADD, src_a: SRC_A_RS1, src_b: SRC_B_RS2,
        is_word: 1'b0, is_mul: 1'b0, is_div: 1'b0,
        mem_read: 1'b0, mem_write: 1'b0, mem_size: MEM_BYTE, mem_unsigned: 1'b0,
        branch: 1'b0, jump: 1'b0, jalr: 1'b0,
        csr_op: CSR_NONE, csr_addr: '0,
        ecall: 1'b0, mret: 1'b0, ebreak: 1'b0,
        illegal: 1'b0
    };

endpackage

// ==== alu_decode.sv ====
module alu_decode
    import rv_isa_pkg::*, decode_ctrl_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  rv_inst_t     inst,
    output logic         hit,
    output decode_ctrl_t ctrl
);

    rv_opcode_t   opcode;
    rv_funct3_t   funct3;
    rv_funct7_t   funct7;
    rv_funct7_t   shift_hi;   // funct7 without shamt[5]
    logic         is_reg;
    logic         is_imm;
    logic         is_word;
    logic         is_shift;
    logic         bad;
    alu_op_e      op;
    decode_ctrl_t c;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign shift_hi = {funct7[6:1], 1'b0};

    assign is_reg   = (opcode == OPC_OP) || (opcode == OPC_OP_32);
    assign is_imm   = (opcode == OPC_OP_IMM) || (opcode == OPC_OP_IMM_32);
    assign is_word  = (opcode == OPC_OP_32) || (opcode == OPC_OP_IMM_32);
    assign is_shift = (funct3 == F3_SLL) || (funct3 == F3_SR);
    assign hit      = is_reg || is_imm;

    always_comb begin
        bad = 1'b0;
        op  = ALU_ADD;
        if (is_reg && funct7 == F7_MULDIV) begin
            case (funct3)
                F3_MUL:  op = ALU_MUL;
                F3_DIV:  op = ALU_DIV;
                F3_DIVU: op = ALU_DIVU;
                F3_REM:  op = ALU_REM;
                F3_REMU: op = ALU_REMU;
                default: bad = 1'b1; // no mulh family
            endcase
        end else begin
            case (funct3)
                F3_ADD:  op = ALU_ADD;
                F3_SLL:  op = ALU_SLL;
                F3_SLT:  op = ALU_SLT;
                F3_SLTU: op = ALU_SLTU;
                F3_XOR:  op = ALU_XOR;
                F3_SR:   op = ALU_SRL;
                F3_OR:   op = ALU_OR;
                F3_AND:  op = ALU_AND;
                default: bad = 1'b1;
            endcase
            if (is_reg) begin
                if (funct7 == F7_ALT) begin
                    if (funct3 == F3_ADD)
                        op = ALU_SUB;
                    else if (funct3 == F3_SR)
                        op = ALU_SRA;
                    else
                        bad = 1'b1;
                end else if (funct7 != F7_BASE) begin
                    bad = 1'b1;
                end
            end else if (is_imm && is_shift) begin
                if (shift_hi == F7_ALT && funct3 == F3_SR)
                    op = ALU_SRA;
                else if (shift_hi != F7_BASE)
                    bad = 1'b1;
                // shamt[5] only exists for 64-bit shifts
                if (funct7[0] && (is_word || XLEN == 32))
                    bad = 1'b1;
            end
        end
        if (is_word && (op inside {ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND}))
            bad = 1'b1;
        if (is_word && XLEN == 32)
            bad = 1'b1; // no word ops on rv32
    end

    always_comb begin
        c = CTRL_NOP;
        if (hit) begin
            c.reg_wen = 1'b1;
            c.rd      = inst[11:7];
            c.rs1     = inst[19:15];
            c.alu_op  = op;
            c.src_a   = SRC_A_RS1;
            c.is_word = is_word;
            c.is_mul  = (op == ALU_MUL);
            c.is_div  = op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
            if (is_reg) begin
                c.rs2     = inst[24:20];
                c.src_b   = SRC_B_RS2;
                c.imm_sel = IMM_NONE;
            end else begin
                c.src_b   = SRC_B_IMM;
                c.imm_sel = is_shift ? IMM_SHAMT : IMM_I;
            end
        end
        if (hit && bad) begin
            ctrl         = CTRL_NOP;
            ctrl.illegal = 1'b1;
        end else begin
            ctrl = c;
        end
    end

endmodule

// ==== mem_decode.sv ====
module mem_decode
    import rv_isa_pkg::*, decode_ctrl_pkg::*;
(
    input  rv_inst_t     inst,
    output logic         hit,
    output decode_ctrl_t ctrl
);

    rv_opcode_t   opcode;
    rv_funct3_t   funct3;
    logic         is_load;
    logic         is_store;
    logic         bad;
    decode_ctrl_t c;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);
    assign hit      = is_load || is_store;

    // funct3 111 load, stores above sd
    assign bad = (is_load && funct3 == 3'b111) || (is_store && funct3[2]);

    always_comb begin
        c = CTRL_NOP;
        if (hit) begin
            c.rs1      = inst[19:15];
            c.alu_op   = ALU_ADD; // address = rs1 + imm
            c.src_a    = SRC_A_RS1;
            c.src_b    = SRC_B_IMM;
            c.mem_size = mem_size_e'(funct3[1:0]);
        end
        if (is_load) begin
            c.imm_sel      = IMM_I;
            c.reg_wen      = 1'b1;
            c.rd           = inst[11:7];
            c.mem_read     = 1'b1;
            c.mem_unsigned = funct3[2];
        end
        if (is_store) begin
            c.imm_sel   = IMM_S;
            c.rs2       = inst[24:20];
            c.mem_write = 1'b1;
        end
        if (bad) begin
            ctrl         = CTRL_NOP;
            ctrl.illegal = 1'b1;
        end else begin
            ctrl = c;
        end
    end

endmodule

// ==== flow_decode.sv ====
module flow_decode
    import rv_isa_pkg::*, decode_ctrl_pkg::*;
(
    input  rv_inst_t     inst,
    output logic         hit,
    output decode_ctrl_t ctrl
);

    rv_opcode_t   opcode;
    rv_funct3_t   funct3;
    logic         bad;
    decode_ctrl_t c;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign hit    = opcode inside {OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LUI, OPC_AUIPC};

    always_comb begin
        c   = CTRL_NOP;
        bad = 1'b0;
        case (opcode)
            OPC_JAL, OPC_JALR: begin
                c.jump    = 1'b1;
                c.reg_wen = 1'b1;
                c.rd      = inst[11:7];
                c.src_a   = SRC_A_PC; // link value pc + 4
                c.src_b   = SRC_B_FOUR;
                c.imm_sel = IMM_J;
                if (opcode == OPC_JALR) begin
                    c.jalr    = 1'b1;
                    c.rs1     = inst[19:15];
                    c.imm_sel = IMM_I;
                    bad       = (funct3 != 3'b000);
                end
            end
            OPC_BRANCH: begin
                c.branch  = 1'b1;
                c.rs1     = inst[19:15];
                c.rs2     = inst[24:20];
                c.imm_sel = IMM_B;
                case (funct3)
                    F3_BEQ:  c.alu_op = ALU_EQ;
                    F3_BNE:  c.alu_op = ALU_NE;
                    F3_BLT:  c.alu_op = ALU_LT;
                    F3_BGE:  c.alu_op = ALU_GE;
                    F3_BLTU: c.alu_op = ALU_LTU;
                    F3_BGEU: c.alu_op = ALU_GEU;
                    default: bad = 1'b1; // 010, 011
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                c.reg_wen = 1'b1;
                c.rd      = inst[11:7];
                c.src_a   = (opcode == OPC_LUI) ? SRC_A_ZERO : SRC_A_PC;
                c.src_b   = SRC_B_IMM;
                c.imm_sel = IMM_U;
            end
            default: ;
        endcase
        if (bad) begin
            ctrl         = CTRL_NOP;
            ctrl.illegal = 1'b1;
        end else begin
            ctrl = c;
        end
    end

endmodule

// ==== system_decode.sv ====
module system_decode
    import rv_isa_pkg::*, decode_ctrl_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  rv_inst_t          inst,
    input  logic [XLEN-1:0]   mtvec,
    input  logic [XLEN-1:0]   mepc,
    output logic              hit,
    output decode_ctrl_t      ctrl,
    output logic [XLEN-1:0]   trap_pc
);

    rv_opcode_t   opcode;
    rv_funct3_t   funct3;
    logic         bad;
    decode_ctrl_t c;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign hit    = (opcode == OPC_SYSTEM);

    always_comb begin
        c       = CTRL_NOP;
        bad     = 1'b0;
        trap_pc = '0;
        if (hit) begin
            if (funct3 == F3_CSRRW || funct3 == F3_CSRRS) begin
                c.reg_wen  = 1'b1; // old csr value to rd
                c.rd       = inst[11:7];
                c.rs1      = inst[19:15];
                c.csr_addr = inst[31:20];
                c.csr_op   = (funct3 == F3_CSRRW) ? CSR_RW : CSR_RS;
            end else if (inst == INST_ECALL) begin
                c.ecall = 1'b1;
                trap_pc = mtvec;
            end else if (inst == INST_MRET) begin
                c.mret  = 1'b1;
                trap_pc = mepc;
            end else if (inst == INST_EBREAK) begin
                c.ebreak = 1'b1;
            end else begin
                bad = 1'b1; // csrrc, immediate csr forms, wfi ...
            end
        end
        if (bad) begin
            ctrl         = CTRL_NOP;
            ctrl.illegal = 1'b1;
        end else begin
            ctrl = c;
        end
    end

endmodule

// ==== inst_decode.sv ====
module inst_decode
    import rv_isa_pkg::*, decode_ctrl_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  rv_inst_t        inst,
    input  logic [XLEN-1:0] mtvec,
    input  logic [XLEN-1:0] mepc,
    output logic            ctrl_valid,
    output decode_ctrl_t    ctrl,
    output logic [XLEN-1:0] trap_pc
);

    logic            alu_hit;
    logic            mem_hit;
    logic            flow_hit;
    logic            sys_hit;
    logic            any_hit;
    decode_ctrl_t    alu_ctrl;
    decode_ctrl_t    mem_ctrl;
    decode_ctrl_t    flow_ctrl;
    decode_ctrl_t    sys_ctrl;
    decode_ctrl_t    next_ctrl;
    logic [XLEN-1:0] sys_trap_pc;

    alu_decode #(
        .XLEN(XLEN)
    ) u_alu (
        .inst (inst),
        .hit  (alu_hit),
        .ctrl (alu_ctrl)
    );

    mem_decode u_mem (
        .inst (inst),
        .hit  (mem_hit),
        .ctrl (mem_ctrl)
    );

    flow_decode u_flow (
        .inst (inst),
        .hit  (flow_hit),
        .ctrl (flow_ctrl)
    );

    system_decode #(
        .XLEN(XLEN)
    ) u_sys (
        .inst    (inst),
        .mtvec   (mtvec),
        .mepc    (mepc),
        .hit     (sys_hit),
        .ctrl    (sys_ctrl),
        .trap_pc (sys_trap_pc)
    );

    assign any_hit = alu_hit | mem_hit | flow_hit | sys_hit;

    // one-hot hits, idle decoders output all zeros
    always_comb begin
        if (any_hit) begin
            next_ctrl = decode_ctrl_t'(alu_ctrl | mem_ctrl | flow_ctrl | sys_ctrl);
        end else begin
            next_ctrl         = CTRL_NOP;
            next_ctrl.illegal = 1'b1; // unknown opcode
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_valid <= 1'b0;
            ctrl       <= CTRL_NOP;
        end else begin
            ctrl_valid <= inst_valid;
            if (inst_valid)
                ctrl <= next_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid)
            trap_pc <= sys_trap_pc; // mtvec/mepc as sampled with inst
    end

endmodule

// ==== inst_decode_properties.sv ====
module inst_decode_properties
    import decode_ctrl_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         inst_valid,
    input logic         ctrl_valid,
    input decode_ctrl_t ctrl
);
    timeunit 1ns;
    timeprecision 1ps;

    int         fail_count = 0;
    logic [7:0] kinds;

    // one kind of instruction per bundle
    assign kinds = {ctrl.branch, ctrl.jump, ctrl.mem_read, ctrl.mem_write,
                    ctrl.csr_op != CSR_NONE, ctrl.ecall, ctrl.mret, ctrl.ebreak};

    a_idle_after_reset: assert property (@(posedge clk) rst |=> !ctrl_valid)
        else begin
            fail_count++;
            $error("ctrl_valid high in the cycle after reset");
        end

    a_valid_follows: assert property (@(posedge clk) disable iff (rst)
                                      ##1 ctrl_valid == $past(inst_valid))
        else begin
            fail_count++;
            $error("ctrl_valid does not follow inst_valid by one cycle");
        end

    a_one_kind: assert property (@(posedge clk) disable iff (rst) $onehot0(kinds))
        else begin
            fail_count++;
            $error("more than one instruction kind set in ctrl");
        end

    a_illegal_quiet: assert property (@(posedge clk) disable iff (rst)
                                      ctrl.illegal |-> !ctrl.reg_wen && !ctrl.mem_write)
        else begin
            fail_count++;
            $error("illegal bundle writes a register or memory");
        end

endmodule

// ==== tb_inst_decode.sv ====
module tb_inst_decode
    import rv_isa_pkg::*, decode_ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INST = 4000;
    localparam int DRAIN_LIMIT = 20;

    logic         clk = 1'b0;
    logic         rst;
    logic         inst_valid;
    rv_inst_t     inst;
    logic [63:0]  mtvec;
    logic [63:0]  mepc;
    logic         ctrl_valid;
    decode_ctrl_t ctrl;
    logic [63:0]  trap_pc;

    logic [15:0]  lfsr = 16'd54;
    int           cycle = 0;
    int           checks = 0;
    int           value_errors = 0;
    int           proto_errors = 0;
    decode_ctrl_t exp_q[$];
    logic [63:0]  pc_q[$];
    int           cyc_q[$];
    decode_ctrl_t last_ctrl = CTRL_NOP;
    logic [63:0]  last_pc = '0;
    logic         seen_valid = 1'b0;

    inst_decode #(
        .XLEN(64)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .mtvec      (mtvec),
        .mepc       (mepc),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl),
        .trap_pc    (trap_pc)
    );

    bind inst_decode inst_decode_properties u_props (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // fibonacci taps x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic rv_inst_t gen_inst();
        rv_inst_t   w;
        logic [3:0] cls;
        logic [1:0] pick;
        w    = rand_bits(32); // random register fields and immediates
        cls  = 4'(rand_bits(4));
        pick = 2'(rand_bits(2));
        case (cls)
            4'd0, 4'd1: begin
                w[6:0] = cls[0] ? OPC_OP_32 : OPC_OP;
                case (pick)
                    2'd0: w[31:25] = F7_BASE;
                    2'd1: w[31:25] = F7_ALT;
                    2'd2: w[31:25] = F7_MULDIV;
                    default: ; // random funct7
                endcase
            end
            4'd2, 4'd3: begin
                w[6:0] = cls[0] ? OPC_OP_IMM_32 : OPC_OP_IMM;
                if (pick != 2'd3)
                    w[31:26] = pick[0] ? 6'b010000 : 6'b000000;
            end
            4'd4: w[6:0] = OPC_LOAD;
            4'd5: w[6:0] = OPC_STORE;
            4'd6: w[6:0] = OPC_BRANCH;
            4'd7: w[6:0] = OPC_JAL;
            4'd8: begin
                w[6:0] = OPC_JALR;
                if (pick != 2'd3)
                    w[14:12] = 3'b000;
            end
            4'd9: w[6:0] = OPC_LUI;
            4'd10: w[6:0] = OPC_AUIPC;
            4'd11: begin
                w[6:0]   = OPC_SYSTEM;
                w[14:12] = pick[0] ? F3_CSRRS : F3_CSRRW;
            end
            4'd12: begin
                case (pick)
                    2'd0: w = INST_ECALL;
                    2'd1: w = INST_MRET;
                    2'd2: w = INST_EBREAK;
                    default: w[6:0] = OPC_SYSTEM;
                endcase
            end
            default: ; // fully random word
        endcase
        return w;
    endfunction

    function automatic void ref_decode(input rv_inst_t i, input logic [63:0] tvec,
                                       input logic [63:0] epc, output decode_ctrl_t c,
                                       output logic [63:0] tpc);
        rv_opcode_t opc;
        rv_funct3_t f3;
        rv_funct7_t f7;
        logic       imm;
        logic       word;
        logic       bad;
        opc  = i[6:0];
        f3   = i[14:12];
        f7   = i[31:25];
        imm  = opc inside {OPC_OP_IMM, OPC_OP_IMM_32};
        word = opc inside {OPC_OP_32, OPC_OP_IMM_32};
        bad  = 1'b0;
        c    = CTRL_NOP;
        tpc  = '0;
        case (opc)
            OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32: begin
                c.reg_wen = 1'b1;
                c.rd      = i[11:7];
                c.rs1     = i[19:15];
                c.is_word = word;
                c.rs2     = imm ? 5'd0 : i[24:20];
                c.src_b   = imm ? SRC_B_IMM : SRC_B_RS2;
                c.imm_sel = !imm ? IMM_NONE : (f3 inside {3'b001, 3'b101}) ? IMM_SHAMT : IMM_I;
                if (!imm && f7 == F7_MULDIV) begin
                    case (f3)
                        3'b000: c.alu_op = ALU_MUL;
                        3'b100: c.alu_op = ALU_DIV;
                        3'b101: c.alu_op = ALU_DIVU;
                        3'b110: c.alu_op = ALU_REM;
                        3'b111: c.alu_op = ALU_REMU;
                        default: bad = 1'b1; // mulh family
                    endcase
                    c.is_mul = (f3 == 3'b000);
                    c.is_div = f3[2];
                end else begin
                    case (f3)
                        3'b000: c.alu_op = (!imm && f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                        3'b001: c.alu_op = ALU_SLL;
                        3'b010: c.alu_op = ALU_SLT;
                        3'b011: c.alu_op = ALU_SLTU;
                        3'b100: c.alu_op = ALU_XOR;
                        3'b101: c.alu_op = (f7[6:1] == 6'b010000) ? ALU_SRA : ALU_SRL;
                        3'b110: c.alu_op = ALU_OR;
                        default: c.alu_op = ALU_AND;
                    endcase
                    if (!imm)
                        bad = !(f7 == F7_BASE || (f7 == F7_ALT && f3 inside {3'b000, 3'b101}));
                    else if (f3 inside {3'b001, 3'b101})
                        bad = !(f7[6:1] == 6'd0 || (f7[6:1] == 6'b010000 && f3 == 3'b101))
                              || (word && f7[0]); // shamt[5] on a word shift
                    if (word && f3 inside {3'b010, 3'b011, 3'b100, 3'b110, 3'b111})
                        bad = 1'b1;
                end
            end
            OPC_LOAD, OPC_STORE: begin
                c.rs1      = i[19:15];
                c.src_b    = SRC_B_IMM;
                c.mem_size = mem_size_e'(f3[1:0]);
                if (opc == OPC_LOAD) begin
                    c.reg_wen      = 1'b1;
                    c.rd           = i[11:7];
                    c.imm_sel      = IMM_I;
                    c.mem_read     = 1'b1;
                    c.mem_unsigned = f3[2];
                    bad            = (f3 == 3'b111);
                end else begin
                    c.rs2       = i[24:20];
                    c.imm_sel   = IMM_S;
                    c.mem_write = 1'b1;
                    bad         = f3[2];
                end
            end
            OPC_JAL, OPC_JALR: begin
                c.jump    = 1'b1;
                c.reg_wen = 1'b1;
                c.rd      = i[11:7];
                c.src_a   = SRC_A_PC;
                c.src_b   = SRC_B_FOUR;
                c.imm_sel = (opc == OPC_JAL) ? IMM_J : IMM_I;
                if (opc == OPC_JALR) begin
                    c.jalr = 1'b1;
                    c.rs1  = i[19:15];
                    bad    = (f3 != 3'b000);
                end
            end
            OPC_BRANCH: begin
                c.branch  = 1'b1;
                c.rs1     = i[19:15];
                c.rs2     = i[24:20];
                c.imm_sel = IMM_B;
                case (f3)
                    3'b000: c.alu_op = ALU_EQ;
                    3'b001: c.alu_op = ALU_NE;
                    3'b100: c.alu_op = ALU_LT;
                    3'b101: c.alu_op = ALU_GE;
                    3'b110: c.alu_op = ALU_LTU;
                    3'b111: c.alu_op = ALU_GEU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_LUI, OPC_AUIPC: begin
                c.reg_wen = 1'b1;
                c.rd      = i[11:7];
                c.src_a   = (opc == OPC_LUI) ? SRC_A_ZERO : SRC_A_PC;
                c.src_b   = SRC_B_IMM;
                c.imm_sel = IMM_U;
            end
            OPC_SYSTEM: begin
                if (f3 == 3'b001 || f3 == 3'b010) begin
                    c.reg_wen  = 1'b1;
                    c.rd       = i[11:7];
                    c.rs1      = i[19:15];
                    c.csr_addr = i[31:20];
                    c.csr_op   = (f3 == 3'b001) ? CSR_RW : CSR_RS;
                end else if (i == INST_ECALL) begin
                    c.ecall = 1'b1;
                    tpc     = tvec;
                end else if (i == INST_MRET) begin
                    c.mret = 1'b1;
                    tpc    = epc;
                end else if (i == INST_EBREAK) begin
                    c.ebreak = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
            default: bad = 1'b1; // unknown opcode
        endcase
        if (bad) begin
            c         = CTRL_NOP;
            c.illegal = 1'b1;
        end
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        decode_ctrl_t e;
        logic [63:0]  epc;
        int           ecyc;
        if (!rst && ctrl_valid) begin
            assert (exp_q.size() > 0) else begin
                proto_errors++;
                $display("ctrl_valid went high at %0t with no instruction outstanding", $time);
            end
            if (exp_q.size() > 0) begin
                e    = exp_q.pop_front();
                epc  = pc_q.pop_front();
                ecyc = cyc_q.pop_front();
                assert (cycle == ecyc + 1) else begin
                    proto_errors++;
                    $display("result at %0t came %0d cycles after its strobe", $time, cycle - ecyc);
                end
                check_field("reg_wen", 64'(ctrl.reg_wen), 64'(e.reg_wen));
                check_field("rd", 64'(ctrl.rd), 64'(e.rd));
                check_field("rs1", 64'(ctrl.rs1), 64'(e.rs1));
                check_field("rs2", 64'(ctrl.rs2), 64'(e.rs2));
                check_field("imm_sel", 64'(ctrl.imm_sel), 64'(e.imm_sel));
                check_field("alu_op", 64'(ctrl.alu_op), 64'(e.alu_op));
                check_field("src_a", 64'(ctrl.src_a), 64'(e.src_a));
                check_field("src_b", 64'(ctrl.src_b), 64'(e.src_b));
                check_field("is_word", 64'(ctrl.is_word), 64'(e.is_word));
                check_field("is_mul", 64'(ctrl.is_mul), 64'(e.is_mul));
                check_field("is_div", 64'(ctrl.is_div), 64'(e.is_div));
                check_field("mem_read", 64'(ctrl.mem_read), 64'(e.mem_read));
                check_field("mem_write", 64'(ctrl.mem_write), 64'(e.mem_write));
                check_field("mem_size", 64'(ctrl.mem_size), 64'(e.mem_size));
                check_field("mem_unsigned", 64'(ctrl.mem_unsigned), 64'(e.mem_unsigned));
                check_field("branch", 64'(ctrl.branch), 64'(e.branch));
                check_field("jump", 64'(ctrl.jump), 64'(e.jump));
                check_field("jalr", 64'(ctrl.jalr), 64'(e.jalr));
                check_field("csr_op", 64'(ctrl.csr_op), 64'(e.csr_op));
                check_field("csr_addr", 64'(ctrl.csr_addr), 64'(e.csr_addr));
                check_field("ecall", 64'(ctrl.ecall), 64'(e.ecall));
                check_field("mret", 64'(ctrl.mret), 64'(e.mret));
                check_field("ebreak", 64'(ctrl.ebreak), 64'(e.ebreak));
                check_field("illegal", 64'(ctrl.illegal), 64'(e.illegal));
                check_field("trap_pc", trap_pc, epc);
                last_ctrl  = e;
                last_pc    = epc;
                seen_valid = 1'b1;
            end
        end else if (!rst) begin
            // outputs hold between strobes
            check_field("held ctrl", 64'(ctrl != last_ctrl), 64'd0);
            if (seen_valid)
                check_field("held trap_pc", trap_pc, last_pc);
        end
    end

    initial begin
        int           issued;
        int           wait_cnt;
        int           total;
        decode_ctrl_t e;
        logic [63:0]  epc;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        mtvec      = '0;
        mepc       = '0;
        issued     = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk); // idle before the first strobe
        while (issued < NUM_INST) begin
            inst  = gen_inst();
            mtvec = {rand_bits(32), rand_bits(32)};
            mepc  = {rand_bits(32), rand_bits(32)};
            if (2'(rand_bits(2)) != 2'b00) begin
                ref_decode(inst, mtvec, mepc, e, epc);
                exp_q.push_back(e);
                pc_q.push_back(epc);
                cyc_q.push_back(cycle);
                inst_valid = 1'b1;
                issued++;
            end else begin
                inst_valid = 1'b0;
            end
            @(negedge clk);
        end
        inst_valid = 1'b0;
        wait_cnt   = 0;
        while (exp_q.size() > 0 && wait_cnt < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        repeat (3) @(negedge clk);
        total = value_errors + proto_errors + u_dut.u_props.fail_count;
        $display("checks %0d, value errors %0d, protocol errors %0d, assertion failures %0d",
                 checks, value_errors, proto_errors, u_dut.u_props.fail_count);
        if (exp_q.size() > 0)
            $display("timed out with %0d decode results never returned", exp_q.size());
        if (exp_q.size() == 0 && total == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
rv_isa_pkg.sv
decode_ctrl_pkg.sv
alu_decode.sv
mem_decode.sv
flow_decode.sv
system_decode.sv
inst_decode.sv
inst_decode_properties.sv
tb_inst_decode.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_inst_decode -f filelist.f -o sim_inst_decode
	./obj_dir/sim_inst_decode +verilator+error+limit+1000 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
